// File: ngInt.f
+incdir+hdl
hdl/ruptPkg.sv
hdl/ruptLatch.sv
hdl/ruptInhibit.sv
hdl/ruptPriority.sv
hdl/ngInt.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbNgInt.sv

// File: run.sh
#!/bin/sh
# Build the ngInt testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbNgInt -f ngInt.f -o VtbNgInt
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VtbNgInt > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
fi
echo "No pass line in $LOG"
exit 1

// File: verification/tbNgInt.sv
`include "ruptCtl_macros.svh"

module tbNgInt;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROUNDS = 150; // Random rounds
	localparam int ROUND_CYCLES = 40; // Longest round
	localparam int MARGIN = 500; // Reset and directed tests
	localparam int CYCLE_LIMIT = ROUNDS * ROUND_CYCLES + MARGIN;
	localparam logic [15:0] BASE_ADDR = 16'h0400; // Octal 2000
	localparam logic [`CP_WIDTH-1:0] CP_ONE = {{(`CP_WIDTH-1){1'b0}}, 1'b1};

	logic CLK2;
	logic rst_RUPT1;
	logic [2:0] src; // Bit 0 T3, bit 1 T4, bit 2 KBD
	logic [`CP_WIDTH-1:0] cp; // Active-low pulses
	logic [`BUS_WIDTH-1:0] writeBus;
	logic [`BUS_WIDTH-1:0] intBus;
	logic irq;

	logic [2:0] mPend; // Model request latches
	logic [2:0] seen1; // Source sampled one edge back
	logic [2:0] seen2; // Two edges back
	logic [2:0] seen3; // Three edges back
	logic mProgInh; // Model program inhibit
	logic mOvfInh; // Model overflow inhibit
	logic [2:0] mCell; // Model vector cell
	logic expIrq;
	logic [15:0] expBus;
	logic checkEn;

	logic [31:0] lfsr;
	int cycleCnt = 0;
	int errCount;
	int checkCount;
	int testErrStart;
	int testsRun;
	int failedTests;

	tbClock clkGen (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1)
	);

	ngInt DUT (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.timer3Pulse_i(src[0]),
		.timer4Pulse_i(src[1]),
		.kbdStrobe_i(src[2]),
		.cp_i(cp),
		.writeBus_i(writeBus),
		.intBus_o(intBus),
		.irq_o(irq)
	);

	tbChecker scoreboard (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.checkEn_i(checkEn),
		.expIrq_i(expIrq),
		.expBus_i(expBus),
		.irq_i(irq),
		.intBus_i(intBus),
		.errCount_o(errCount),
		.checkCount_o(checkCount)
	);

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// Vector code of the highest pending source
	function automatic logic [2:0] topCode(input logic [2:0] p);
		if (p[0])
			return 3'd1; // T3
		if (p[1])
			return 3'd3; // T4
		if (p[2])
			return 3'd4; // KBD
		return 3'd0;
	endfunction

	task automatic predictOutputs();
		expIrq = !mProgInh && !mOvfInh && (mPend != 3'b000) && (mCell == 3'd0);
		expBus = BASE_ADDR | {11'b0, mCell, 2'b00}; // Base plus code times four
	endtask

	task automatic modelReset();
		mPend = 3'b000;
		seen1 = 3'b000;
		seen2 = 3'b000;
		seen3 = 3'b000;
		mProgInh = 1'b0;
		mOvfInh = 1'b0;
		mCell = 3'd0;
		predictOutputs();
	endtask

	// One rising edge with the inputs that were driven before it
	task automatic modelEdge();
		logic [2:0] rise;
		logic [2:0] clr;
		logic gen;
		logic ovf;
		gen = ~cp[`CP_GENRST];
		ovf = writeBus[15] ^ writeBus[14]; // Sign bits disagree
		rise = seen2 & ~seen3; // Source went high two samples ago
		clr = ~cp[`CP_KRPT] ? (mPend & (~mPend + 3'd1)) : 3'b000; // Lowest bit wins
		if (gen || ~cp[`CP_CLRP])
			mCell = 3'd0;
		else if (~cp[`CP_RPT])
			mCell = topCode(mPend);
		mPend = rise | (mPend & ~clr & ~{3{gen}}); // New edge beats the clear
		if (gen)
			mProgInh = 1'b0;
		else if (~cp[`CP_INH])
			mProgInh = 1'b1;
		else if (~cp[`CP_CLINH])
			mProgInh = 1'b0;
		if (gen)
			mOvfInh = 1'b0;
		else if (~cp[`CP_WOVI] && ovf)
			mOvfInh = 1'b1;
		else if (~cp[`CP_CLINH1])
			mOvfInh = 1'b0;
		seen3 = seen2;
		seen2 = seen1;
		seen1 = src;
		predictOutputs();
	endtask

	task automatic tick();
		@(posedge CLK2);
		@(negedge CLK2); // Inputs change here
		modelEdge();
		cp = '1; // Pulses last one cycle
	endtask

	task automatic waitCycles(input int n);
		repeat (n) tick();
	endtask

	task automatic firePulse(input int idx);
		cp = ~(CP_ONE << idx);
		tick();
	endtask

	task automatic pulseSources(input logic [2:0] mask);
		src = mask; // High for one cycle
		tick();
		src = 3'b000;
		tick();
	endtask

	// Read, knock down and release; an extra edge lands on the knock-down edge
	task automatic serviceOne(input logic [2:0] extra);
		src = extra;
		tick();
		src = 3'b000;
		firePulse(`CP_RPT);
		firePulse(`CP_KRPT);
		firePulse(`CP_CLRP);
	endtask

	task automatic drainPending();
		int iter;
		iter = 0;
		while ((mPend != 3'b000) && (iter < 6)) begin
			serviceOne((takeBits(2) == 0) ? 3'(takeBits(3)) : 3'b000);
			iter++;
		end
	endtask

	task automatic randomRound();
		logic [1:0] kind;
		logic [2:0] mask;
		kind = 2'(takeBits(2));
		mask = 3'(takeBits(3));
		case (kind)
			2'd0: begin // Program inhibit holds irq off
				firePulse(`CP_INH);
				pulseSources(mask);
				waitCycles(4);
				firePulse(`CP_CLINH);
			end
			2'd1: begin // Overflow check on a random word
				writeBus = 16'(takeBits(16));
				firePulse(`CP_WOVI);
				pulseSources(mask);
				waitCycles(4);
				firePulse(`CP_CLINH1);
			end
			default: begin
				pulseSources(mask);
				waitCycles(4);
			end
		endcase
		drainPending();
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errCount == testErrStart) begin
			$display("test %s: passed", name);
		end else begin
			failedTests++;
			$display("test %s: failed with %0d mismatches", name, errCount - testErrStart);
		end
		testErrStart = errCount;
	endtask

	always @(posedge CLK2) begin
		if (rst_RUPT1)
			cycleCnt <= cycleCnt + 1;
	end

	initial begin : watchdog
		wait (cycleCnt >= CYCLE_LIMIT);
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		lfsr = 32'hbc15;
		src = 3'b000;
		cp = '1; // No pulses
		writeBus = '0;
		checkEn = 1'b0;
		testErrStart = 0;
		testsRun = 0;
		failedTests = 0;
		modelReset();
		@(posedge rst_RUPT1);
		checkEn = 1'b1;
		waitCycles(3);
		endTest("reset");
		for (int i = 0; i < 3; i++) begin
			pulseSources(3'b001 << i);
			waitCycles(4);
			firePulse(`CP_RPT); // Bus shows 0404, 040C or 0410
			firePulse(`CP_KRPT);
			firePulse(`CP_CLRP);
			waitCycles(1);
		end
		endTest("single source");
		repeat (ROUNDS) randomRound();
		waitCycles(4);
		drainPending();
		endTest("random rounds");
		firePulse(`CP_INH);
		writeBus = 16'h8000; // Overflowed word
		firePulse(`CP_WOVI);
		pulseSources(3'b111);
		waitCycles(4);
		firePulse(`CP_RPT);
		firePulse(`CP_GENRST);
		waitCycles(2);
		pulseSources(3'b100); // Raises irq_o only with both inhibits gone
		waitCycles(4);
		firePulse(`CP_RPT); // Keyboard is the only request left
		firePulse(`CP_KRPT);
		firePulse(`CP_CLRP);
		endTest("general reset");
		$display("Tests %0d, failed %0d, checks %0d, mismatches %0d", testsRun, failedTests,
			checkCount, errCount);
		if (errCount == 0 && failedTests == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verification/tbChecker.sv
module tbChecker (
	input logic CLK2, // Testbench clock
	input logic rst_RUPT1, // Active-low reset
	input logic checkEn_i, // Model is in step with the DUT
	input logic expIrq_i, // Predicted interrupt request
	input logic [15:0] expBus_i, // Predicted vector address
	input logic irq_i, // DUT irq_o
	input logic [15:0] intBus_i, // DUT intBus_o
	output int errCount_o, // Mismatches so far
	output int checkCount_o // Compares so far
);
	timeunit 1ns;
	timeprecision 1ps;

	int errs = 0; // Mismatch counter
	int checks = 0; // Compare counter
	int cycle = 0; // Clock count for the log

	assign errCount_o = errs;
	assign checkCount_o = checks;

	// Outputs only move on rising edges, so the values just before the edge are settled
	always @(posedge CLK2) begin
		cycle++;
		if (rst_RUPT1 && checkEn_i) begin
			checks++;
			if (irq_i !== expIrq_i) begin
				errs++;
				$display("[FAIL] irq_o exp=%h got=%h (cycle %0d)", expIrq_i, irq_i, cycle);
			end
			if (intBus_i !== expBus_i) begin
				errs++;
				$display("[FAIL] intBus_o exp=%h got=%h (cycle %0d)", expBus_i, intBus_i,
					cycle);
			end
		end
	end

endmodule

// File: verification/tbClock.sv
module tbClock (
	output logic CLK2, // 50 MHz testbench clock
	output logic rst_RUPT1 // Active-low reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		CLK2 = 1'b0;
		forever #10 CLK2 = ~CLK2; // 20 ns period
	end

	initial begin
		rst_RUPT1 = 1'b0; // Held through four rising edges
		repeat (4) @(posedge CLK2);
		@(negedge CLK2);
		rst_RUPT1 = 1'b1; // Released away from the sampling edge
	end

endmodule

// File: hdl/ngInt.sv
`include "ruptCtl_macros.svh"

module ngInt (
	input logic CLK2, // System clock
	input logic rst_RUPT1, // Async reset, active low
	input logic timer3Pulse_i, // Timer T3 request
	input logic timer4Pulse_i, // Timer T4 request
	input logic kbdStrobe_i, // Keyboard strobe
	input logic [`CP_WIDTH-1:0] cp_i, // Control pulses, active low
	input logic [`BUS_WIDTH-1:0] writeBus_i, // Write bus for overflow
	output logic [`BUS_WIDTH-1:0] intBus_o, // Vector address
	output logic irq_o // Interrupt request
);

	ruptPkg::ctlPulse_t ctl; // Active-high pulses
	logic [2:0] pending; // Latched requests
	logic [2:0] clearVec; // Knock-down per source
	logic intEnable; // Inhibits released

	// Pick and invert the pulses this unit uses
	assign ctl.genRst = ~cp_i[`CP_GENRST];
	assign ctl.rpt = ~cp_i[`CP_RPT];
	assign ctl.clrp = ~cp_i[`CP_CLRP];
	assign ctl.inh = ~cp_i[`CP_INH];
	assign ctl.clinh = ~cp_i[`CP_CLINH];
	assign ctl.clinh1 = ~cp_i[`CP_CLINH1];
	assign ctl.wovi = ~cp_i[`CP_WOVI];
	assign ctl.krpt = ~cp_i[`CP_KRPT];

	ruptLatch u_t3 (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.src_i(timer3Pulse_i),
		.clear_i(clearVec[0]),
		.genRst_i(ctl.genRst),
		.pending_o(pending[0])
	);

	ruptLatch u_t4 (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.src_i(timer4Pulse_i),
		.clear_i(clearVec[1]),
		.genRst_i(ctl.genRst),
		.pending_o(pending[1])
	);

	ruptLatch u_kbd (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.src_i(kbdStrobe_i),
		.clear_i(clearVec[2]),
		.genRst_i(ctl.genRst),
		.pending_o(pending[2])
	);

	ruptInhibit u_inhibit (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.ctl_i(ctl),
		.writeBus_i(writeBus_i),
		.intEnable_o(intEnable)
	);

	ruptPriority u_priority (
		.CLK2(CLK2),
		.rst_RUPT1(rst_RUPT1),
		.ctl_i(ctl),
		.pending_i(pending),
		.intEnable_i(intEnable),
		.clearVec_o(clearVec),
		.irq_o(irq_o),
		.intBus_o(intBus_o)
	);

endmodule

// File: hdl/ruptPriority.sv
`include "ruptCtl_macros.svh"

module ruptPriority (
	input logic CLK2, // System clock
	input logic rst_RUPT1, // Async reset, active low
	input ruptPkg::ctlPulse_t ctl_i, // Decoded control pulses
	input logic [2:0] pending_i, // Bit 0 T3, bit 1 T4, bit 2 KBD
	input logic intEnable_i, // No inhibit active
	output logic [2:0] clearVec_o, // Knock-down per source
	output logic irq_o, // Request to sequencer
	output logic [`BUS_WIDTH-1:0] intBus_o // Vector address
);

	ruptPkg::ruptVec_t vecSel; // Code of highest pending source
	ruptPkg::ruptVec_t vecCell; // Vector in service
	logic [2:0] clrSel; // One-hot of highest pending source
	logic anyPending; // At least one request waiting
	logic cellIdle; // No interrupt in service

	// Fixed priority, T3 first, then T4, then keyboard
	always_comb begin
		if (pending_i[0]) begin
			vecSel = ruptPkg::VEC_T3; // Highest
			clrSel = 3'b001;
		end else if (pending_i[1]) begin
			vecSel = ruptPkg::VEC_T4;
			clrSel = 3'b010;
		end else if (pending_i[2]) begin
			vecSel = ruptPkg::VEC_KBD; // Lowest
			clrSel = 3'b100;
		end else begin
			vecSel = ruptPkg::VEC_NONE; // Nothing to service
			clrSel = 3'b000;
		end
	end

	assign anyPending = |pending_i;

	// Vector cell, clear has priority over load
	always_ff @(posedge CLK2 or negedge rst_RUPT1) begin
		if (!rst_RUPT1) begin
			vecCell <= ruptPkg::VEC_NONE;
		end else if (ctl_i.genRst) begin
			vecCell <= ruptPkg::VEC_NONE; // General reset
		end else if (ctl_i.clrp) begin
			vecCell <= ruptPkg::VEC_NONE; // End of service
		end else if (ctl_i.rpt) begin
			vecCell <= vecSel; // Capture winner
		end
	end

	assign cellIdle = (vecCell == ruptPkg::VEC_NONE);

	// Knock down only the winning latch, same edge as krpt
	assign clearVec_o = ctl_i.krpt ? clrSel : 3'b000;

	// Request while enabled and nothing in service
	assign irq_o = intEnable_i & anyPending & cellIdle;

	// Base address, cell code times four
	assign intBus_o = {`RUPT_BASE, vecCell, 2'b00};

	// The sequencer reads a vector only with none in service
	rptOnlyWhenIdle: assert property (
		@(posedge CLK2) disable iff (!rst_RUPT1)
		ctl_i.rpt |-> cellIdle
	) else $error("rpt while vector %0h in service", vecCell);

endmodule

// File: hdl/ruptInhibit.sv
`include "ruptCtl_macros.svh"

module ruptInhibit (
	input logic CLK2, // System clock
	input logic rst_RUPT1, // Async reset, active low
	input ruptPkg::ctlPulse_t ctl_i, // Decoded control pulses
	input logic [`BUS_WIDTH-1:0] writeBus_i, // Word being written
	output logic intEnable_o // Interrupts allowed
);

	logic progInh; // INHINT, set by program
	logic ovfInh; // INHINT1, set on overflow
	logic ovfWord; // Sign bits disagree

	// Overflow shows as a mismatch of the two top bits
	assign ovfWord = writeBus_i[`BUS_WIDTH-1] ^ writeBus_i[`BUS_WIDTH-2];

	// Program inhibit flop
	always_ff @(posedge CLK2 or negedge rst_RUPT1) begin
		if (!rst_RUPT1) begin
			progInh <= 1'b0;
		end else if (ctl_i.genRst) begin
			progInh <= 1'b0; // Sync clear
		end else if (ctl_i.inh) begin
			progInh <= 1'b1; // INHINT instruction
		end else if (ctl_i.clinh) begin
			progInh <= 1'b0; // RELINT instruction
		end
	end

	// Overflow inhibit flop
	always_ff @(posedge CLK2 or negedge rst_RUPT1) begin
		if (!rst_RUPT1) begin
			ovfInh <= 1'b0;
		end else if (ctl_i.genRst) begin
			ovfInh <= 1'b0; // Sync clear
		end else if (ctl_i.wovi && ovfWord) begin
			ovfInh <= 1'b1; // Overflowed write
		end else if (ctl_i.clinh1) begin
			ovfInh <= 1'b0; // Overflow handled
		end
	end

	// Enabled only with both inhibits released
	assign intEnable_o = ~progInh & ~ovfInh;

	// The sequencer never issues INHINT and RELINT in one cycle
	inhClinhExclusive: assert property (
		@(posedge CLK2) disable iff (!rst_RUPT1)
		!(ctl_i.inh && ctl_i.clinh)
	) else $error("inh and clinh asserted together");

endmodule

// File: hdl/ruptLatch.sv
module ruptLatch (
	input logic CLK2, // System clock
	input logic rst_RUPT1, // Async reset, active low
	input logic src_i, // Async request level
	input logic clear_i, // Knock-down for this source
	input logic genRst_i, // Sync general reset
	output logic pending_o // Request waiting for service
);

	logic syncQ1; // First sync stage
	logic syncQ2; // Second sync stage, safe to use
	logic prevQ; // Last synced value
	logic riseEdge; // Rising edge of synced source
	logic pendingQ; // Sticky request flop

	// Two-stage synchronizer plus history flop
	always_ff @(posedge CLK2 or negedge rst_RUPT1) begin
		if (!rst_RUPT1) begin
			syncQ1 <= 1'b0;
			syncQ2 <= 1'b0;
			prevQ <= 1'b0;
		end else begin
			syncQ1 <= src_i; // May go metastable
			syncQ2 <= syncQ1;
			prevQ <= syncQ2;
		end
	end

	assign riseEdge = syncQ2 & ~prevQ; // One cycle per source pulse

	// Sticky latch; a fresh edge wins over any clear so no request is lost
	always_ff @(posedge CLK2 or negedge rst_RUPT1) begin
		if (!rst_RUPT1) begin
			pendingQ <= 1'b0;
		end else if (riseEdge) begin
			pendingQ <= 1'b1; // Set, even during knock-down
		end else if (clear_i || genRst_i) begin
			pendingQ <= 1'b0; // Serviced or reset
		end
	end

	assign pending_o = pendingQ;

	// Knock-down only ever reaches a latch that holds a request
	clearOnlyWhenPending: assert property (
		@(posedge CLK2) disable iff (!rst_RUPT1)
		clear_i |-> pendingQ
	) else $error("clear without a pending request");

endmodule

// File: hdl/ruptPkg.sv
package ruptPkg;

	// Vector cell codes, one per interrupt source
	// Bus address is base plus code times four
	typedef enum logic [2:0] {
		VEC_NONE = 3'd0, // Nothing in service
		VEC_T3 = 3'd1, // Timer T3, address 2004 octal
		VEC_T4 = 3'd3, // Timer T4, address 2014 octal
		VEC_KBD = 3'd4 // Keyboard, address 2020 octal
	} ruptVec_t;

	// Decoded control pulses, active high
	// One-cycle levels sampled on CLK2
	typedef struct packed {
		logic genRst; // General reset
		logic rpt; // Load vector cell
		logic clrp; // Clear vector cell
		logic inh; // Set program inhibit
		logic clinh; // Clear program inhibit
		logic clinh1; // Clear overflow inhibit
		logic wovi; // Overflow check on write bus
		logic krpt; // Knock down serviced request
	} ctlPulse_t;

endpackage

// File: hdl/ruptCtl_macros.svh
`ifndef RUPTCTL_MACROS_SVH
`define RUPTCTL_MACROS_SVH

// Control-pulse vector from the sequencer, all pulses active low
`define CP_WIDTH 101 // Full pulse vector width

// Bit index of each pulse used by the interrupt unit
`define CP_GENRST 2 // General reset
`define CP_RPT 58 // Read RUPT opcode
`define CP_CLRP 64 // Clear vector cell
`define CP_INH 66 // Set program inhibit
`define CP_CLINH 67 // Clear program inhibit
`define CP_CLINH1 68 // Clear overflow inhibit
`define CP_WOVI 99 // Write overflow RUPT inhibit
`define CP_KRPT 49 // Knock down RUPT priority

// Upper 11 bits of the vector address, octal 2000 once the cell
// and the two low zero bits are appended
`define RUPT_BASE 11'h020

// Data bus width of the machine
`define BUS_WIDTH 16

`endif
